// ==== hdl/heapPkg.sv ====
//------------------------------
// Heap package
// Widths, counts, command codes and error codes
//------------------------------
package heapPkg;

  //------------------------------
  // Sizes
  //------------------------------
  localparam int ArrayBits   = 2;                       // Bits in an array handle
  localparam int NumArrays   = 1 << ArrayBits;          // Arrays in the heap
  localparam int CountBits   = ArrayBits + 1;           // Holds 0 to NumArrays
  localparam int IndexBits   = 2;                       // Bits in an element index
  localparam int ArrayLength = 1 << IndexBits;          // Elements per array
  localparam int SizeBits    = IndexBits + 1;           // A full size fits
  localparam int DataBits    = 12;                      // Element width

  //------------------------------
  // Commands
  //------------------------------
  typedef enum logic [7:0] {
    Reset    = 8'd1,                                    // Clear all handles
    Write    = 8'd2,
    Read     = 8'd3,
    Size     = 8'd4,
    Push     = 8'd14,
    Pop      = 8'd15,
    Alloc    = 8'd18,
    Free     = 8'd19,
    Add      = 8'd20,                                   // Returns new value
    AddAfter = 8'd21,                                   // Returns old value
    Subtract = 8'd22,                                   // Returns new value
    SubAfter = 8'd23                                    // Returns old value
  } actionT;

  typedef enum logic [7:0] {
    noError      = 8'd0,
    notAllocated = 8'd1,                                // Handle never issued
    freedArray   = 8'd2,
    outOfBounds  = 8'd3,
    emptyArray   = 8'd4,
    fullArray    = 8'd5,
    outOfMemory  = 8'd6,
    badAction    = 8'd7                                 // Unknown command code
  } errorT;

  // Write source of the element store
  typedef enum logic [1:0] {
    store    = 2'd0,
    add      = 2'd1,
    subtract = 2'd2
  } updateT;

endpackage

// ==== hdl/arrayTable.sv ====
//------------------------------
// Array table
// Allocation flag and live size per array
//------------------------------
`timescale 1ns/1ps

module arrayTable import heapPkg::*; (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic [ArrayBits-1:0] handle,
  input  logic                 markAllocated,
  input  logic                 markFreed,
  input  logic                 setSize,
  input  logic [SizeBits-1:0]  newSize,
  input  logic                 clearAll,
  output logic                 isAllocated,
  output logic [SizeBits-1:0]  arraySize
);

  logic [NumArrays-1:0] allocated;                    // One flag per array
  logic [SizeBits-1:0]  sizes [NumArrays];            // Live element counts

  assign isAllocated = allocated[handle];
  assign arraySize   = sizes[handle];

  //------------------------------
  // Flag and size updates
  //------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated <= '0;
      for (int i = 0; i < NumArrays; i++) begin
        sizes[i] <= '0;
      end
    end else if (clearAll) begin
      allocated <= '0;                                // Heap clear
      for (int i = 0; i < NumArrays; i++) begin
        sizes[i] <= '0;
      end
    end else begin
      if (markAllocated) begin
        allocated[handle] <= 1'b1;
        sizes[handle]     <= '0;                      // New array starts empty
      end
      if (markFreed) allocated[handle] <= 1'b0;
      if (setSize)   sizes[handle]     <= newSize;    // Write, Push or Pop
    end
  end

  // Control must never grow an array past its block
  sizeInRange: assert property (
    @(posedge clock) disable iff (!resetN) setSize |-> newSize <= SizeBits'(ArrayLength)
  ) else $error("array size beyond ArrayLength");

endmodule

// ==== hdl/elementStore.sv ====
//------------------------------
// Element store
// Element memory with in-place add and subtract
//------------------------------
`timescale 1ns/1ps

module elementStore import heapPkg::*; (
  input  logic                 clock,
  input  logic [ArrayBits-1:0] storeHandle,
  input  logic [IndexBits-1:0] storeIndex,
  input  logic [DataBits-1:0]  operand,
  input  logic                 storeWrite,
  input  updateT               update,
  output logic [DataBits-1:0]  element,
  output logic [DataBits-1:0]  updated
);

  logic [DataBits-1:0] memory [NumArrays][ArrayLength];   // One block per array

  assign element = memory[storeHandle][storeIndex];

  //------------------------------
  // New element value
  //------------------------------
  always_comb begin
    case (update)
      add:      updated = element + operand;           // Wraps at DataBits
      subtract: updated = element - operand;
      default:  updated = operand;                     // Plain store
    endcase
  end

  // Contents survive the heap clear
  always_ff @(posedge clock) begin
    if (storeWrite) begin
      memory[storeHandle][storeIndex] <= updated;
    end
  end

endmodule

// ==== hdl/heapAllocator.sv ====
//------------------------------
// Heap allocator
// Stack of freed handles plus a count of
// handles issued, supplying the next handle
//------------------------------
`timescale 1ns/1ps

module heapAllocator import heapPkg::*; (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 allocate,
  input  logic                 releaseEn,
  input  logic [ArrayBits-1:0] releasedHandle,
  input  logic                 clearAll,
  output logic [ArrayBits-1:0] nextHandle,
  output logic                 canAlloc,
  output logic [CountBits-1:0] issuedCount
);

  logic [ArrayBits-1:0] freeStack [NumArrays];        // Freed handles
  logic [CountBits-1:0] stackTop;                     // Entries on the stack
  logic                 stackEmpty;
  logic [ArrayBits-1:0] topIndex;                     // Slot of the top entry

  assign stackEmpty = stackTop == '0;
  assign topIndex   = stackTop[ArrayBits-1:0] - 1'b1;
  assign nextHandle = stackEmpty ? issuedCount[ArrayBits-1:0] : freeStack[topIndex];
  assign canAlloc   = !stackEmpty || issuedCount < CountBits'(NumArrays);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop    <= '0;
      issuedCount <= '0;
    end else if (clearAll) begin
      stackTop    <= '0;                              // Every handle forgotten
      issuedCount <= '0;
    end else if (allocate) begin
      if (stackEmpty) issuedCount <= issuedCount + 1'b1;
      else            stackTop    <= stackTop - 1'b1; // Reuse last freed
    end else if (releaseEn) begin
      stackTop <= stackTop + 1'b1;
    end
  end

  // Handle storage
  always_ff @(posedge clock) begin
    if (releaseEn && !clearAll && !allocate) begin
      freeStack[stackTop[ArrayBits-1:0]] <= releasedHandle;
    end
  end

  stackNoOverflow: assert property (
    @(posedge clock) disable iff (!resetN) releaseEn |-> stackTop < CountBits'(NumArrays)
  ) else $error("free stack overflow");

  stackNoUnderflow: assert property (
    @(posedge clock) disable iff (!resetN) allocate |-> canAlloc
  ) else $error("allocation with no handle left");

endmodule

// ==== hdl/heapControl.sv ====
//------------------------------
// Heap control
// Decodes a command, checks it, drives the datapath
// enables and registers result, error and done
//------------------------------
`timescale 1ns/1ps

module heapControl import heapPkg::*; (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 request,
  input  actionT               action,
  input  logic [ArrayBits-1:0] arrayId,
  input  logic [IndexBits-1:0] index,
  input  logic [DataBits-1:0]  operand,
  input  logic [ArrayBits-1:0] nextHandle,
  input  logic                 canAlloc,
  input  logic [CountBits-1:0] issuedCount,
  input  logic                 isAllocated,
  input  logic [SizeBits-1:0]  arraySize,
  input  logic [DataBits-1:0]  element,
  input  logic [DataBits-1:0]  updated,
  output logic [DataBits-1:0]  result,
  output errorT                error,
  output logic                 done,
  output logic [ArrayBits-1:0] tableHandle,
  output logic                 allocate,
  output logic                 releaseEn,
  output logic                 clearAll,
  output logic                 setSize,
  output logic [SizeBits-1:0]  newSize,
  output logic                 markAllocated,
  output logic                 markFreed,
  output logic [ArrayBits-1:0] storeHandle,
  output logic [IndexBits-1:0] storeIndex,
  output logic                 storeWrite,
  output updateT               update
);

  logic                knownAction;                   // Command code recognised
  logic                needsArray;                    // Handle must be live
  logic                needsIndex;                    // Index must be inside size
  logic                legal;                         // Request passes every check
  errorT               nextError;
  logic [DataBits-1:0] nextResult;

  //------------------------------
  // Decode and checks
  //------------------------------
  always_comb begin
    knownAction = 1'b1;
    needsArray  = 1'b1;
    needsIndex  = 1'b0;
    storeIndex  = index;
    newSize     = SizeBits'(index) + 1'b1;             // Write grows to index plus one
    case (action)
      Reset, Alloc:                      needsArray = 1'b0;
      Read, Add, AddAfter, Subtract, SubAfter: needsIndex = 1'b1;
      Push: begin
        storeIndex = arraySize[IndexBits-1:0];         // Slot above the top
        newSize    = arraySize + 1'b1;
      end
      Pop: begin
        storeIndex = IndexBits'(arraySize - 1'b1);     // Current top
        newSize    = arraySize - 1'b1;
      end
      Write, Size, Free:                 needsArray = 1'b1;
      default:                           knownAction = 1'b0;
    endcase

    if (!knownAction)                                               nextError = badAction;
    else if (needsArray && {1'b0, arrayId} >= issuedCount)          nextError = notAllocated;
    else if (needsArray && !isAllocated)                            nextError = freedArray;
    else if (needsIndex && SizeBits'(index) >= arraySize)           nextError = outOfBounds;
    else if (action == Push && arraySize == SizeBits'(ArrayLength)) nextError = fullArray;
    else if (action == Pop && arraySize == '0)                      nextError = emptyArray;
    else if (action == Alloc && !canAlloc)                          nextError = outOfMemory;
    else                                                            nextError = noError;
  end

  assign legal       = request && nextError == noError;
  assign tableHandle = (action == Alloc) ? nextHandle : arrayId;   // New array for Alloc
  assign storeHandle = arrayId;

  //------------------------------
  // Datapath enables
  //------------------------------
  assign allocate      = legal && action == Alloc;
  assign markAllocated = legal && action == Alloc;
  assign releaseEn     = legal && action == Free;
  assign markFreed     = legal && action == Free;
  assign clearAll      = legal && action == Reset;
  assign storeWrite    = legal && action inside {Write, Push, Add, AddAfter, Subtract, SubAfter};
  assign setSize       = legal && ((action == Write && SizeBits'(index) >= arraySize) ||
                                   action == Push || action == Pop);

  always_comb begin
    case (action)
      Add, AddAfter:      update = add;
      Subtract, SubAfter: update = subtract;
      default:            update = store;
    endcase
  end

  // Reset and Free leave the result word alone
  always_comb begin
    case (action)
      Write, Push:                  nextResult = operand;
      Read, Pop, AddAfter, SubAfter: nextResult = element;
      Add, Subtract:                nextResult = updated;
      Size:                         nextResult = DataBits'(arraySize);
      Alloc:                        nextResult = DataBits'(nextHandle);
      default:                      nextResult = result;
    endcase
  end

  //------------------------------
  // Response registers
  //------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      result <= '0;
      error  <= noError;
      done   <= 1'b0;
    end else begin
      done <= request;                                 // One cycle answer
      if (request) error <= nextError;
      if (legal) result <= nextResult;                 // Held on error
    end
  end

  // Alloc never hands out a live array
  allocTargetsFreeArray: assert property (
    @(posedge clock) disable iff (!resetN) allocate |-> !isAllocated
  ) else $error("Alloc returned a handle that is still allocated");

endmodule

// ==== hdl/heapUnit.sv ====
//------------------------------
// Heap unit
// Control and datapath wired together
//------------------------------
`timescale 1ns/1ps

module heapUnit import heapPkg::*; (
  input  logic                 clock,
  input  logic                 resetN,
  input  logic                 request,
  input  actionT               action,
  input  logic [ArrayBits-1:0] arrayId,
  input  logic [IndexBits-1:0] index,
  input  logic [DataBits-1:0]  operand,
  output logic [DataBits-1:0]  result,
  output errorT                error,
  output logic                 done
);

  logic [ArrayBits-1:0] nextHandle;
  logic                 canAlloc;
  logic [CountBits-1:0] issuedCount;
  logic                 isAllocated;
  logic [SizeBits-1:0]  arraySize;
  logic [DataBits-1:0]  element;
  logic [DataBits-1:0]  updated;
  logic [ArrayBits-1:0] tableHandle;                  // Alloc target or arrayId
  logic                 allocate;
  logic                 releaseEn;
  logic                 clearAll;
  logic                 setSize;
  logic [SizeBits-1:0]  newSize;
  logic                 markAllocated;
  logic                 markFreed;
  logic [ArrayBits-1:0] storeHandle;
  logic [IndexBits-1:0] storeIndex;
  logic                 storeWrite;
  updateT               update;

  heapControl control_i (
    .clock, .resetN, .request, .action, .arrayId, .index, .operand,
    .nextHandle, .canAlloc, .issuedCount, .isAllocated, .arraySize,
    .element, .updated, .result, .error, .done, .tableHandle,
    .allocate, .releaseEn, .clearAll, .setSize, .newSize, .markAllocated,
    .markFreed, .storeHandle, .storeIndex, .storeWrite, .update
  );

  heapAllocator allocator_i (
    .clock, .resetN, .allocate, .releaseEn, .releasedHandle(arrayId),
    .clearAll, .nextHandle, .canAlloc, .issuedCount
  );

  arrayTable table_i (
    .clock, .resetN, .handle(tableHandle), .markAllocated, .markFreed,
    .setSize, .newSize, .clearAll, .isAllocated, .arraySize
  );

  elementStore store_i (
    .clock, .storeHandle, .storeIndex, .operand, .storeWrite, .update,
    .element, .updated
  );

endmodule

// ==== tests/heapUnitTb.sv ====
//------------------------------
// Heap unit testbench
// Directed and random commands checked
// against a reference model by assertions
//------------------------------
`timescale 1ns/1ps

module heapUnitTb import heapPkg::*; ();

  logic                 clock;
  logic                 resetN;
  logic                 request;
  actionT               action;
  logic [ArrayBits-1:0] arrayId;
  logic [IndexBits-1:0] index;
  logic [DataBits-1:0]  operand;
  logic [DataBits-1:0]  result;
  errorT                error;
  logic                 done;

  //------------------------------
  // Reference model
  //------------------------------
  logic                 flags [NumArrays];
  int                   sizes [NumArrays];
  logic [DataBits-1:0]  contents [NumArrays][ArrayLength];
  int                   issued;                           // Handles ever issued
  logic [ArrayBits-1:0] freeStack [$];                    // Freed handles with top at back
  logic [DataBits-1:0]  lastResult;

  errorT                expError;
  logic [DataBits-1:0]  expResult;
  logic                 requestQ;                         // Request of the previous edge
  errorT                expErrorQ;
  logic [DataBits-1:0]  expResultQ;
  int                   errorCount;
  int                   timeoutCount;

  heapUnit dut_i (
    .clock, .resetN, .request, .action, .arrayId, .index, .operand,
    .result, .error, .done
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  // Expected response lines up with the cycle of done
  always @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      requestQ   <= 1'b0;
      expErrorQ  <= noError;
      expResultQ <= '0;
    end else begin
      requestQ   <= request;
      expErrorQ  <= expError;
      expResultQ <= expResult;
    end
  end

  //------------------------------
  // Checks
  //------------------------------
  doneFollowsRequest: assert property (
    @(posedge clock) disable iff (!resetN) done == requestQ
  ) else begin
    errorCount++;
    $display("ERROR %0t done: got %b expected %b", $time, $sampled(done), $sampled(requestQ));
  end

  errorMatchesModel: assert property (
    @(posedge clock) disable iff (!resetN) requestQ |-> error == expErrorQ
  ) else begin
    errorCount++;
    $display("ERROR %0t error: got %0d expected %0d", $time, $sampled(error),
             $sampled(expErrorQ));
  end

  resultMatchesModel: assert property (
    @(posedge clock) disable iff (!resetN)
      requestQ && expErrorQ == noError |-> result == expResultQ
  ) else begin
    errorCount++;
    $display("ERROR %0t result: got %h expected %h", $time, $sampled(result),
             $sampled(expResultQ));
  end

  function automatic void clearModel();
    for (int a = 0; a < NumArrays; a++) begin
      flags[a] = 1'b0;
      sizes[a] = 0;
    end
    issued = 0;
    freeStack.delete();
  endfunction

  // Updates the model, then drives the command just after the edge
  task automatic sendCommand(input actionT act, input logic [ArrayBits-1:0] id,
                             input logic [IndexBits-1:0] idx, input logic [DataBits-1:0] opnd);
    errorT                e;
    logic [DataBits-1:0]  r;
    logic [ArrayBits-1:0] handle;
    logic [IndexBits-1:0] slot;
    bit                   live;
    bit                   indexed;
    live    = act inside {Write, Read, Size, Push, Pop, Free, Add, AddAfter, Subtract, SubAfter};
    indexed = act inside {Read, Add, AddAfter, Subtract, SubAfter};
    r       = lastResult;                                 // Held on error
    if (!(live || act == Reset || act == Alloc))   e = badAction;
    else if (live && int'(id) >= issued)           e = notAllocated;
    else if (live && !flags[id])                   e = freedArray;
    else if (indexed && int'(idx) >= sizes[id])    e = outOfBounds;
    else if (act == Push && sizes[id] == ArrayLength) e = fullArray;
    else if (act == Pop && sizes[id] == 0)         e = emptyArray;
    else if (act == Alloc && freeStack.size() == 0 && issued == NumArrays) e = outOfMemory;
    else                                           e = noError;
    if (e == noError) begin
      case (act)
        Reset: clearModel();                              // Contents survive
        Alloc: begin
          if (freeStack.size() > 0) begin
            handle = freeStack.pop_back();                // Last freed comes back first
          end else begin
            handle = ArrayBits'(issued);
            issued++;
          end
          flags[handle] = 1'b1;
          sizes[handle] = 0;
          r = DataBits'(handle);
        end
        Free: begin
          flags[id] = 1'b0;
          freeStack.push_back(id);
        end
        Write: begin
          contents[id][idx] = opnd;
          if (int'(idx) >= sizes[id]) sizes[id] = int'(idx) + 1;
          r = opnd;
        end
        Read: r = contents[id][idx];
        Size: r = DataBits'(sizes[id]);
        Push: begin
          slot = IndexBits'(sizes[id]);
          contents[id][slot] = opnd;
          sizes[id]++;
          r = opnd;
        end
        Pop: begin
          sizes[id]--;
          slot = IndexBits'(sizes[id]);
          r = contents[id][slot];
        end
        Add: begin
          contents[id][idx] = contents[id][idx] + opnd;   // Wraps at DataBits
          r = contents[id][idx];
        end
        AddAfter: begin
          r = contents[id][idx];
          contents[id][idx] = r + opnd;
        end
        Subtract: begin
          contents[id][idx] = contents[id][idx] - opnd;
          r = contents[id][idx];
        end
        SubAfter: begin
          r = contents[id][idx];
          contents[id][idx] = r - opnd;
        end
        default: ;
      endcase
      lastResult = r;
    end
    @(posedge clock);
    #1;
    request   = 1'b1;
    action    = act;
    arrayId   = id;
    index     = idx;
    operand   = opnd;
    expError  = e;
    expResult = r;
  endtask

  task automatic idleCycle();
    @(posedge clock);
    #1;
    request = 1'b0;
  endtask

  // Ends the request stream and looks for the last done
  task automatic waitForDone();
    int cycles;
    cycles = 0;
    idleCycle();
    do begin
      @(negedge clock);
      cycles++;
    end while (done !== 1'b1 && cycles < 8);
    if (done !== 1'b1) begin
      timeoutCount++;
      $display("Timeout: no done pulse within %0d cycles after a request", cycles);
    end
  endtask

  function automatic actionT randomAction();
    int unsigned pick;
    actionT      act;
    pick = $urandom % 64;
    case (pick % 11)
      0:       act = Write;
      1:       act = Read;
      2:       act = Size;
      3:       act = Push;
      4:       act = Pop;
      5:       act = Alloc;
      6:       act = Free;
      7:       act = Add;
      8:       act = AddAfter;
      9:       act = Subtract;
      default: act = SubAfter;
    endcase
    if (pick == 0) act = Reset;                           // Rare heap clear
    else if (pick < 3) act = actionT'(8'd9);              // Unused code
    return act;
  endfunction

  task automatic finishRun();
    $display("Run complete: %0d value errors, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  //------------------------------
  // Stimulus
  //------------------------------
  initial begin
    void'($urandom(32'heb55_2235));
    resetN       = 1'b0;
    request      = 1'b0;
    action       = Size;
    arrayId      = '0;
    index        = '0;
    operand      = '0;
    expError     = noError;
    expResult    = '0;
    lastResult   = '0;
    errorCount   = 0;
    timeoutCount = 0;
    clearModel();
    repeat (5) @(posedge clock);
    #1;
    resetN = 1'b1;
    @(negedge clock);
    assert (done === 1'b0 && error === noError && result === '0) else begin
      errorCount++;
      $display("ERROR %0t done/error/result after reset: got %b/%0d/%h expected 0/0/000",
               $time, done, error, result);
    end

    sendCommand(Size, 2'd2, 2'd0, 12'h0);                 // Never issued
    sendCommand(actionT'(8'd9), 2'd0, 2'd0, 12'h0);
    waitForDone();
    repeat (5) sendCommand(Alloc, 2'd0, 2'd0, 12'h0);     // Fifth runs out
    for (int a = 0; a < NumArrays; a++) begin
      for (int i = ArrayLength - 1; i >= 0; i--) begin
        sendCommand(Write, ArrayBits'(a), IndexBits'(i), DataBits'($urandom));
      end
      sendCommand(Size, ArrayBits'(a), 2'd0, 12'h0);
      sendCommand(Read, ArrayBits'(a), IndexBits'(a), 12'h0);
    end
    waitForDone();

    // Handle reuse
    sendCommand(Free, 2'd1, 2'd0, 12'h0);
    sendCommand(Free, 2'd3, 2'd0, 12'h0);
    sendCommand(Alloc, 2'd0, 2'd0, 12'h0);
    sendCommand(Alloc, 2'd0, 2'd0, 12'h0);
    sendCommand(Free, 2'd2, 2'd0, 12'h0);
    sendCommand(Read, 2'd2, 2'd0, 12'h0);
    sendCommand(Free, 2'd2, 2'd0, 12'h0);                 // Already freed
    sendCommand(Alloc, 2'd0, 2'd0, 12'h0);

    // Sparse write into a fresh array
    sendCommand(Read, 2'd1, 2'd0, 12'h0);
    sendCommand(Write, 2'd1, 2'd2, 12'h5a5);
    sendCommand(Size, 2'd1, 2'd0, 12'h0);
    sendCommand(Read, 2'd1, 2'd2, 12'h0);
    sendCommand(Read, 2'd1, 2'd0, 12'h0);
    sendCommand(Read, 2'd1, 2'd3, 12'h0);
    waitForDone();

    // Stack use of array 3
    sendCommand(Pop, 2'd3, 2'd0, 12'h0);
    for (int i = 0; i < ArrayLength + 1; i++) begin
      sendCommand(Push, 2'd3, 2'd0, DataBits'(12'h100 + i));
    end
    for (int i = 0; i < ArrayLength + 1; i++) begin
      sendCommand(Pop, 2'd3, 2'd0, 12'h0);
    end

    // Arithmetic with wrap
    sendCommand(Add, 2'd0, 2'd1, 12'hfff);
    sendCommand(AddAfter, 2'd0, 2'd1, 12'h801);
    sendCommand(Subtract, 2'd0, 2'd2, 12'hfff);
    sendCommand(SubAfter, 2'd0, 2'd2, 12'h800);
    sendCommand(Read, 2'd0, 2'd1, 12'h0);
    sendCommand(Read, 2'd0, 2'd2, 12'h0);
    waitForDone();

    sendCommand(Reset, 2'd0, 2'd0, 12'h0);
    for (int a = 0; a < NumArrays; a++) begin
      sendCommand(Size, ArrayBits'(a), 2'd0, 12'h0);
    end
    waitForDone();

    for (int n = 0; n < 400; n++) begin
      if ($urandom % 8 == 0) idleCycle();
      sendCommand(randomAction(), ArrayBits'($urandom), IndexBits'($urandom),
                  DataBits'($urandom));
    end
    waitForDone();
    finishRun();
  end

endmodule

// ==== all.f ====
hdl/heapPkg.sv
hdl/arrayTable.sv
hdl/elementStore.sv
hdl/heapAllocator.sv
hdl/heapControl.sv
hdl/heapUnit.sv
tests/heapUnitTb.sv

// ==== Makefile ====
# Verilator flow for the heap unit

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = heapUnitTb
FILELIST  = all.f
OBJDIR    = obj_dir
PASSTEXT  = TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep "$(PASSTEXT)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
